//--- project.f
+incdir+src
src/lsu_result_pkg.sv
src/lsu_arb_pkg.sv
src/lsu_result_if.sv
src/result_fifo.sv
src/rr_arbiter.sv
src/lsu_arbiter.sv
src/lsu_writeback_top.sv
verification/tb_lsu_writeback.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU write-back testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_lsu_writeback
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench reported it
if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

//--- verification/tb_lsu_writeback.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_lsu_writeback;

    localparam int DEPTH = `LSU_RESULT_FIFO_DEPTH;

    // One result beat as the reference model keeps it
    typedef struct packed {
        lsu_result_pkg::trans_id_t  trans_id;
        lsu_result_pkg::result_t    result;
        logic                       ex_valid;
        lsu_result_pkg::exc_cause_t ex_cause;
        lsu_result_pkg::exc_tval_t  ex_tval;
    } beat_t;

    logic clk_i;
    logic reset_i;
    logic flush_i;
    logic ld_valid_i;
    logic st_valid_i;
    beat_t ld_beat;
    beat_t st_beat;

    logic                       valid_o;
    lsu_result_pkg::trans_id_t  trans_id_o;
    lsu_result_pkg::result_t    result_o;
    logic                       ex_valid_o;
    lsu_result_pkg::exc_cause_t ex_cause_o;
    lsu_result_pkg::exc_tval_t  ex_tval_o;

    // Reference model with one queue per path mirroring the FIFO contents
    beat_t ld_q[$];
    beat_t st_q[$];
    lsu_arb_pkg::arb_prio_e prio;
    // Beat the DUT should present in the current cycle
    logic  exp_valid;
    logic  exp_from_st;
    beat_t exp_beat;
    // Events at the previous edge
    logic flush_q;
    logic reset_q;
    logic idle_push_q;

    int push_count;
    int flushed_count;
    int dut_out_count;
    int err_count;
    int tie_count;
    int full_count;
    int flush_count;
    logic [31:0] rng_state;

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    lsu_writeback_top i_dut (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .ld_valid_i    (ld_valid_i),
        .ld_trans_id_i (ld_beat.trans_id),
        .ld_result_i   (ld_beat.result),
        .ld_ex_valid_i (ld_beat.ex_valid),
        .ld_ex_cause_i (ld_beat.ex_cause),
        .ld_ex_tval_i  (ld_beat.ex_tval),
        .st_valid_i    (st_valid_i),
        .st_trans_id_i (st_beat.trans_id),
        .st_result_i   (st_beat.result),
        .st_ex_valid_i (st_beat.ex_valid),
        .st_ex_cause_i (st_beat.ex_cause),
        .st_ex_tval_i  (st_beat.ex_tval),
        .valid_o       (valid_o),
        .trans_id_o    (trans_id_o),
        .result_o      (result_o),
        .ex_valid_o    (ex_valid_o),
        .ex_cause_o    (ex_cause_o),
        .ex_tval_o     (ex_tval_o)
    );

    // xorshift32 generator
    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic beat_t random_beat();
        beat_t b;
        logic [31:0] r;
        r = next_random();
        b.trans_id = r[8 +: `LSU_TRANS_ID_BITS];
        b.result   = {next_random(), next_random()};
        // Roughly one beat in four carries an exception
        b.ex_valid = (r[1:0] == 2'b00);
        b.ex_cause = r[16 +: `LSU_EXC_CAUSE_BITS];
        b.ex_tval  = {next_random(), next_random()};
        return b;
    endfunction

    // Push driven now lands at the next edge and may meet a pop of the head
    function automatic logic can_push(input logic to_st);
        int   size;
        logic pops;
        size = to_st ? st_q.size() : ld_q.size();
        pops = exp_valid && (exp_from_st == to_st);
        return (size < DEPTH) || pops;
    endfunction

    // Lone requester wins outright and a tie goes to the favored side
    function automatic void compute_expected();
        logic ld_has;
        logic st_has;
        ld_has = (ld_q.size() != 0);
        st_has = (st_q.size() != 0);
        exp_valid   = ld_has || st_has;
        exp_from_st = (ld_has && st_has) ? (prio == lsu_arb_pkg::PRIO_ST) : st_has;
        exp_beat    = '0;
        if (exp_from_st) begin
            exp_beat = st_q[0];
        end else if (ld_has) begin
            exp_beat = ld_q[0];
        end
    endfunction

    // Advance the model by one edge using the inputs seen at that edge
    task automatic update_model();
        reset_q     = reset_i;
        flush_q     = flush_i;
        idle_push_q = !reset_i && !flush_i && !exp_valid && (ld_valid_i || st_valid_i);
        if (reset_i) begin
            ld_q.delete();
            st_q.delete();
            prio = lsu_arb_pkg::PRIO_LD;
        end else begin
            // Presented head is consumed even in a flush cycle
            if (exp_valid) begin
                if (ld_q.size() != 0 && st_q.size() != 0) begin
                    tie_count++;
                end
                if (exp_from_st) begin
                    void'(st_q.pop_front());
                end else begin
                    void'(ld_q.pop_front());
                end
                prio = exp_from_st ? lsu_arb_pkg::PRIO_LD : lsu_arb_pkg::PRIO_ST;
            end
            if (flush_i) begin
                flushed_count += ld_q.size() + st_q.size();
                ld_q.delete();
                st_q.delete();
                prio = lsu_arb_pkg::PRIO_LD;
                flush_count++;
            end else begin
                if (ld_valid_i) begin
                    ld_q.push_back(ld_beat);
                    push_count++;
                end
                if (st_valid_i) begin
                    st_q.push_back(st_beat);
                    push_count++;
                end
            end
        end
        if (ld_q.size() == DEPTH && st_q.size() == DEPTH) begin
            full_count++;
        end
        compute_expected();
    endtask

    // Update the model at the edge and then drive the next inputs
    task automatic run_cycle(input logic want_ld, input logic want_st, input logic do_flush);
        @(posedge clk_i);
        update_model();
        ld_valid_i <= want_ld && can_push(1'b0);
        st_valid_i <= want_st && can_push(1'b1);
        ld_beat    <= random_beat();
        st_beat    <= random_beat();
        flush_i    <= do_flush;
    endtask

    // Idle the inputs until the DUT stops presenting results
    task automatic wait_drain();
        int   cycles;
        logic drained;
        cycles  = 0;
        drained = 1'b0;
        while (!drained && cycles < 16) begin
            run_cycle(1'b0, 1'b0, 1'b0);
            @(negedge clk_i);
            drained = (valid_o == 1'b0);
            cycles++;
        end
        if (!drained) begin
            err_count++;
            $display("Timeout: valid_o still high %0d cycles after the last push", cycles);
        end
    endtask

    // Output beats seen by the consumer
    always @(negedge clk_i) begin
        if (reset_i == 1'b0 && valid_o === 1'b1) begin
            dut_out_count++;
        end
    end

    valid_check: assert property (@(posedge clk_i) disable iff (reset_i) valid_o == exp_valid)
        else begin
            err_count++;
            $display("Error: %0t ns valid_o is %b, expected %b",
                     $time, $sampled(valid_o), $sampled(exp_valid));
        end

    // Fields must match the head of the winning path
    payload_check: assert property (@(posedge clk_i) disable iff (reset_i)
        exp_valid |-> ({trans_id_o, result_o, ex_valid_o, ex_cause_o, ex_tval_o} == exp_beat))
        else begin
            err_count++;
            $display("Error: %0t ns %s beat mismatch: trans_id %0d result %h, expected %0d %h",
                     $time, $sampled(exp_from_st) ? "store" : "load", $sampled(trans_id_o),
                     $sampled(result_o), $sampled(exp_beat.trans_id), $sampled(exp_beat.result));
        end

    flush_check: assert property (@(posedge clk_i) disable iff (reset_i) flush_q |-> !valid_o)
        else begin
            err_count++;
            $display("Error: %0t ns valid_o high in the cycle after a flush", $time);
        end

    reset_check: assert property (@(posedge clk_i) reset_q |-> !valid_o)
        else begin
            err_count++;
            $display("Error: %0t ns valid_o high after a reset edge", $time);
        end

    // Push into two idle paths shows up one cycle later
    latency_check: assert property (@(posedge clk_i) disable iff (reset_i) idle_push_q |-> valid_o)
        else begin
            err_count++;
            $display("Error: %0t ns push into idle paths not presented one cycle later", $time);
        end

    initial begin
        logic [31:0] r;
        rng_state     = 32'h6885b451;
        reset_i       = 1'b1;
        flush_i       = 1'b0;
        ld_valid_i    = 1'b0;
        st_valid_i    = 1'b0;
        ld_beat       = '0;
        st_beat       = '0;
        prio          = lsu_arb_pkg::PRIO_LD;
        exp_valid     = 1'b0;
        exp_from_st   = 1'b0;
        exp_beat      = '0;
        flush_q       = 1'b0;
        reset_q       = 1'b0;
        idle_push_q   = 1'b0;
        push_count    = 0;
        flushed_count = 0;
        dut_out_count = 0;
        err_count     = 0;
        tie_count     = 0;
        full_count    = 0;
        flush_count   = 0;

        repeat (3) run_cycle(1'b0, 1'b0, 1'b0);
        reset_i <= 1'b0;
        // Quiet outputs with no traffic
        repeat (4) run_cycle(1'b0, 1'b0, 1'b0);

        // Lone pushes on each path
        run_cycle(1'b1, 1'b0, 1'b0);
        wait_drain();
        run_cycle(1'b0, 1'b1, 1'b0);
        wait_drain();

        // Second lone load while the pointer favors the store side
        run_cycle(1'b1, 1'b0, 1'b0);
        run_cycle(1'b1, 1'b0, 1'b0);
        wait_drain();

        // Both paths loaded so that grants alternate
        run_cycle(1'b1, 1'b1, 1'b0);
        run_cycle(1'b1, 1'b1, 1'b0);
        run_cycle(1'b1, 1'b1, 1'b0);
        wait_drain();

        // Flush with entries pending drops the pushes of the flush cycle too
        run_cycle(1'b1, 1'b1, 1'b0);
        run_cycle(1'b1, 1'b1, 1'b0);
        run_cycle(1'b1, 1'b1, 1'b1);
        run_cycle(1'b1, 1'b1, 1'b0);
        wait_drain();

        // Both paths held at the two-entry limit
        repeat (60) run_cycle(1'b1, 1'b1, 1'b0);
        wait_drain();

        // Random traffic with rare flushes
        repeat (600) begin
            r = next_random();
            run_cycle(r[0] | r[1], r[2] | r[3], r[9:4] == 6'd0);
        end
        wait_drain();

        out_count_check: assert (dut_out_count == push_count - flushed_count)
            else begin
                err_count++;
                $display("Error: %0t ns %0d beats out, expected %0d",
                         $time, dut_out_count, push_count - flushed_count);
            end

        $display("Beats %0d pushes %0d flushed %0d flushes %0d ties %0d full %0d errors %0d",
                 dut_out_count, push_count, flushed_count, flush_count, tie_count,
                 full_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src/lsu_writeback_top.sv
`timescale 1ns/1ps

// LSU write-back stage with plain ports
module lsu_writeback_top (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       flush_i,
    // Load path result
    input  logic                       ld_valid_i,
    input  lsu_result_pkg::trans_id_t  ld_trans_id_i,
    input  lsu_result_pkg::result_t    ld_result_i,
    input  logic                       ld_ex_valid_i,
    input  lsu_result_pkg::exc_cause_t ld_ex_cause_i,
    input  lsu_result_pkg::exc_tval_t  ld_ex_tval_i,
    // Store path result
    input  logic                       st_valid_i,
    input  lsu_result_pkg::trans_id_t  st_trans_id_i,
    input  lsu_result_pkg::result_t    st_result_i,
    input  logic                       st_ex_valid_i,
    input  lsu_result_pkg::exc_cause_t st_ex_cause_i,
    input  lsu_result_pkg::exc_tval_t  st_ex_tval_i,
    // Merged result, consumed every cycle it is valid
    output logic                       valid_o,
    output lsu_result_pkg::trans_id_t  trans_id_o,
    output lsu_result_pkg::result_t    result_o,
    output logic                       ex_valid_o,
    output lsu_result_pkg::exc_cause_t ex_cause_o,
    output lsu_result_pkg::exc_tval_t  ex_tval_o
);

    lsu_result_if ld_res ();
    lsu_result_if st_res ();
    lsu_result_if wb_res ();

    // Load path ports onto its bundle
    assign ld_res.valid    = ld_valid_i;
    assign ld_res.trans_id = ld_trans_id_i;
    assign ld_res.result   = ld_result_i;
    assign ld_res.ex_valid = ld_ex_valid_i;
    assign ld_res.ex_cause = ld_ex_cause_i;
    assign ld_res.ex_tval  = ld_ex_tval_i;

    // Store path ports onto its bundle
    assign st_res.valid    = st_valid_i;
    assign st_res.trans_id = st_trans_id_i;
    assign st_res.result   = st_result_i;
    assign st_res.ex_valid = st_ex_valid_i;
    assign st_res.ex_cause = st_ex_cause_i;
    assign st_res.ex_tval  = st_ex_tval_i;

    lsu_arbiter i_lsu_arbiter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .ld_res  (ld_res.consumer),
        .st_res  (st_res.consumer),
        .wb_res  (wb_res.producer)
    );

    // Merged bundle back out to the ports
    assign valid_o    = wb_res.valid;
    assign trans_id_o = wb_res.trans_id;
    assign result_o   = wb_res.result;
    assign ex_valid_o = wb_res.ex_valid;
    assign ex_cause_o = wb_res.ex_cause;
    assign ex_tval_o  = wb_res.ex_tval;

endmodule

//--- src/lsu_arbiter.sv
`timescale 1ns/1ps

// Buffers load and store results and merges them onto one port
module lsu_arbiter (
    input  logic           clk_i,
    input  logic           reset_i,
    input  logic           flush_i,
    lsu_result_if.consumer ld_res,
    lsu_result_if.consumer st_res,
    lsu_result_if.producer wb_res
);

    // FIFO head beats
    lsu_result_if ld_head ();
    lsu_result_if st_head ();

    logic ld_not_empty;
    logic st_not_empty;
    logic ld_pop;
    logic st_pop;
    logic arb_valid;
    logic arb_idx;

    // Load path buffer
    result_fifo i_ld_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .push_i     (ld_res.valid),
        .wr         (ld_res),
        .pop_i      (ld_pop),
        .rd_valid_o (ld_not_empty),
        .rd         (ld_head.producer)
    );

    // Store path buffer
    result_fifo i_st_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .push_i     (st_res.valid),
        .wr         (st_res),
        .pop_i      (st_pop),
        .rd_valid_o (st_not_empty),
        .rd         (st_head.producer)
    );

    // Grant pops the winning head in the same cycle
    rr_arbiter i_rr_arbiter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .req_i   ({st_not_empty, ld_not_empty}),
        .gnt_o   ({st_pop, ld_pop}),
        .valid_o (arb_valid),
        .idx_o   (arb_idx)
    );

    // Output multiplexer, index 1 picks the store head
    assign wb_res.valid    = arb_valid;
    assign wb_res.trans_id = arb_idx ? st_head.trans_id : ld_head.trans_id;
    assign wb_res.result   = arb_idx ? st_head.result   : ld_head.result;
    assign wb_res.ex_valid = arb_idx ? st_head.ex_valid : ld_head.ex_valid;
    assign wb_res.ex_cause = arb_idx ? st_head.ex_cause : ld_head.ex_cause;
    assign wb_res.ex_tval  = arb_idx ? st_head.ex_tval  : ld_head.ex_tval;

endmodule

//--- src/rr_arbiter.sv
`timescale 1ns/1ps

// Round robin for two requesters
// Bit 0 is the load path, bit 1 the store path
module rr_arbiter (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       flush_i,
    input  logic [1:0] req_i,
    output logic [1:0] gnt_o,
    output logic       valid_o,
    output logic       idx_o
);

    // Side favored on a tie
    lsu_arb_pkg::arb_prio_e prio_q;
    lsu_arb_pkg::arb_prio_e prio_d;

    assign valid_o = |req_i;

    // Winner selection
    always_comb begin
        idx_o = 1'b0;
        case (req_i)
            // Lone requester wins regardless of the pointer
            2'b01: idx_o = 1'b0;
            2'b10: idx_o = 1'b1;
            // Tie goes to the favored side
            2'b11: idx_o = (prio_q == lsu_arb_pkg::PRIO_ST);
            default: idx_o = 1'b0;
        endcase
    end

    // One-hot grant, none without a request
    always_comb begin
        gnt_o = 2'b00;
        if (valid_o) begin
            gnt_o = idx_o ? 2'b10 : 2'b01;
        end
    end

    // After a grant the other side is favored
    always_comb begin
        prio_d = prio_q;
        if (valid_o) begin
            prio_d = idx_o ? lsu_arb_pkg::PRIO_LD : lsu_arb_pkg::PRIO_ST;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            prio_q <= lsu_arb_pkg::PRIO_LD;
        end else begin
            prio_q <= prio_d;
        end
    end

endmodule

//--- src/result_fifo.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

// Result buffer for one path, head read combinationally
module result_fifo (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         flush_i,
    input  logic         push_i,
    lsu_result_if.consumer wr,
    input  logic         pop_i,
    output logic         rd_valid_o,
    lsu_result_if.producer rd
);

    localparam int DEPTH    = `LSU_RESULT_FIFO_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);

    // Payload storage, one array per field
    lsu_result_pkg::trans_id_t  trans_id_mem [DEPTH];
    lsu_result_pkg::result_t    result_mem   [DEPTH];
    logic                       ex_valid_mem [DEPTH];
    lsu_result_pkg::exc_cause_t ex_cause_mem [DEPTH];
    lsu_result_pkg::exc_tval_t  ex_tval_mem  [DEPTH];

    logic [PTR_BITS-1:0]    rd_ptr_q;
    logic [PTR_BITS-1:0]    wr_ptr_q;
    lsu_arb_pkg::fifo_cnt_t cnt_q;

    logic not_empty;
    logic push_en;
    logic pop_en;

    assign not_empty = (cnt_q != '0);

    // Flush cycle drops any incoming beat
    assign push_en = push_i & ~flush_i;
    // Popping an empty FIFO is ignored
    assign pop_en  = pop_i & not_empty;

    // Write the incoming beat into the tail slot
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            trans_id_mem[wr_ptr_q] <= wr.trans_id;
            result_mem[wr_ptr_q]   <= wr.result;
            ex_valid_mem[wr_ptr_q] <= wr.ex_valid;
            ex_cause_mem[wr_ptr_q] <= wr.ex_cause;
            ex_tval_mem[wr_ptr_q]  <= wr.ex_tval;
        end
    end

    // Pointers wrap at the last slot, count tracks occupancy
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            // Push together with pop leaves the count as is
            case ({push_en, pop_en})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    assign rd_valid_o = not_empty;

    // Head beat, valid follows not-empty
    assign rd.valid    = not_empty;
    assign rd.trans_id = trans_id_mem[rd_ptr_q];
    assign rd.result   = result_mem[rd_ptr_q];
    assign rd.ex_valid = ex_valid_mem[rd_ptr_q];
    assign rd.ex_cause = ex_cause_mem[rd_ptr_q];
    assign rd.ex_tval  = ex_tval_mem[rd_ptr_q];

endmodule

//--- src/lsu_result_if.sv
`timescale 1ns/1ps

// One result beat, strobed by valid, no ready
interface lsu_result_if;

    // Beat is taken at the edge where valid is high
    logic                      valid;
    lsu_result_pkg::trans_id_t trans_id;
    lsu_result_pkg::result_t   result;

    // Exception attached to the operation
    logic                       ex_valid;
    lsu_result_pkg::exc_cause_t ex_cause;
    lsu_result_pkg::exc_tval_t  ex_tval;

    // Side that drives the beat
    modport producer (
        output valid,
        output trans_id,
        output result,
        output ex_valid,
        output ex_cause,
        output ex_tval
    );

    // Side that samples the beat
    modport consumer (
        input valid,
        input trans_id,
        input result,
        input ex_valid,
        input ex_cause,
        input ex_tval
    );

endinterface

//--- src/lsu_arb_pkg.sv
`include "lsu_defines.svh"

// Arbitration and FIFO bookkeeping types
package lsu_arb_pkg;

    // Side that wins when both paths request
    typedef enum logic {
        PRIO_LD = 1'b0,
        PRIO_ST = 1'b1
    } arb_prio_e;

    // Occupancy count from zero up to the full depth
    typedef logic [$clog2(`LSU_RESULT_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

endpackage

//--- src/lsu_result_pkg.sv
`include "lsu_defines.svh"

// Field types of one write-back result beat
package lsu_result_pkg;

    // Scoreboard tag of the operation
    typedef logic [`LSU_TRANS_ID_BITS-1:0] trans_id_t;

    // Load data or store result
    typedef logic [`LSU_RESULT_BITS-1:0] result_t;

    // Exception cause code
    typedef logic [`LSU_EXC_CAUSE_BITS-1:0] exc_cause_t;

    // Exception trap value, usually the faulting address
    typedef logic [`LSU_EXC_TVAL_BITS-1:0] exc_tval_t;

endpackage

//--- src/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Write-back stage sizing for the load/store unit

// Scoreboard tag width
`define LSU_TRANS_ID_BITS 3

// Load data or store result word
`define LSU_RESULT_BITS 64

// Exception cause code width
`define LSU_EXC_CAUSE_BITS 6

// Faulting address or value width
`define LSU_EXC_TVAL_BITS 64

// Entries per path FIFO
// At most two operations per path are in flight, so two entries never overflow
`define LSU_RESULT_FIFO_DEPTH 2

`endif
